// File: add_unit.sv
`default_nettype none

`include "alu_cfg.svh"

module add_unit
  import alu_op_pkg::*, alu_data_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  exec_if.sink      ex,
  output logic      done,
  output unit_res_t res
);

  op_code_e             code;
  logic                 is_sub;
  logic                 is_carry;
  logic                 is_mine;
  logic                 is32;
  logic                 cin;
  data_t                b_eff;
  logic [`ALU_DATA_W:0] sum64;
  logic [`ALU_HALF_W:0] sum32;
  data_t                sum;
  flags_t               flags;
  logic                 a_top;
  logic                 b_top;

  assign code     = ex.op.plain.code;
  assign is_sub   = code inside {OP_SUB64, OP_SUB32, OP_CMP64, OP_SBC64};
  assign is_carry = code inside {OP_ADC64, OP_SBC64};
  assign is_mine  = is_sub || is_carry || (code inside {OP_ADD64, OP_ADD32});
  assign is32     = code inside {OP_ADD32, OP_SUB32};

  // the carry class reads the other view of the same word
  assign cin = !is_carry ? is_sub :
               ex.op.carry.carry_from_flags ? ex.flags_in.c : ex.op.carry.carry_fix;

  assign b_eff = is_sub ? ~ex.b : ex.b;
  assign sum64 = {1'b0, ex.a} + {1'b0, b_eff} + (`ALU_DATA_W+1)'(cin);
  assign sum32 = {1'b0, ex.a[`ALU_HALF_W-1:0]} + {1'b0, b_eff[`ALU_HALF_W-1:0]}
               + (`ALU_HALF_W+1)'(cin);

  always_comb begin
    if (is32) begin
      sum     = {{(`ALU_DATA_W-`ALU_HALF_W){1'b0}}, sum32[`ALU_HALF_W-1:0]};
      flags.c = sum32[`ALU_HALF_W];
      flags.z = sum32[`ALU_HALF_W-1:0] == '0;
      flags.s = sum32[`ALU_HALF_W-1];
      a_top   = ex.a[`ALU_HALF_W-1];
      b_top   = b_eff[`ALU_HALF_W-1];
    end else begin
      sum     = sum64[`ALU_DATA_W-1:0];
      flags.c = sum64[`ALU_DATA_W];
      flags.z = sum64[`ALU_DATA_W-1:0] == '0;
      flags.s = sum64[`ALU_DATA_W-1];
      a_top   = ex.a[`ALU_DATA_W-1];
      b_top   = b_eff[`ALU_DATA_W-1];
    end
    // signed overflow when both inputs agree in sign and the result does not
    flags.o = (a_top == b_top) && (flags.s != a_top);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) done <= 1'b0;
    else done <= ex.valid && is_mine;
  end

  always_ff @(posedge clk) begin
    if (ex.valid && is_mine) begin
      res.result <= sum;
      res.flags  <= flags;
      res.we     <= code != OP_CMP64;  // compare only updates flags
    end
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
alu_op_pkg.sv
alu_data_pkg.sv
alu_if.sv
operand_bypass.sv
add_unit.sv
shift_unit.sv
result_merge.sv
alu_lane.sv
tb_alu_lane.sv

// File: alu_cfg.svh
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// full data path of the lane
`define ALU_DATA_W 64

// the 32-bit forms work on the low half only
`define ALU_HALF_W 32

// operation word as issued with the code in the low byte
`define ALU_OP_W 18

// carry, zero, sign, overflow
`define ALU_FLAGS_W 4

`endif

// File: alu_data_pkg.sv
`default_nettype none

`include "alu_cfg.svh"

package alu_data_pkg;

  typedef logic [`ALU_DATA_W-1:0] data_t;

  typedef struct packed {
    logic c;
    logic z;
    logic s;
    logic o;
  } flags_t;

  // what a unit hands to the merge stage
  typedef struct packed {
    data_t  result;
    flags_t flags;
    logic   we;  // low for compares, which only write flags
  } unit_res_t;

endpackage

`default_nettype wire

// File: alu_if.sv
`default_nettype none

// operands and operation as they leave the bypass stage
interface exec_if
  import alu_op_pkg::*, alu_data_pkg::*;
();

  logic    valid;     // one cycle per issued operation
  alu_op_u op;
  data_t   a;
  data_t   b;
  flags_t  flags_in;

  modport src (
    output valid,
    output op,
    output a,
    output b,
    output flags_in
  );

  // each unit checks the opcode itself
  modport sink (
    input valid,
    input op,
    input a,
    input b,
    input flags_in
  );

endinterface

`default_nettype wire

// File: alu_lane.sv
`default_nettype none

`include "alu_cfg.svh"

module alu_lane
  import alu_op_pkg::*, alu_data_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    issue_en,
  input  logic [`ALU_OP_W-1:0]    op,
  input  logic [`ALU_DATA_W-1:0]  a_reg,
  input  logic [`ALU_DATA_W-1:0]  b_reg,
  input  src_sel_e                a_sel,
  input  src_sel_e                b_sel,
  input  logic [`ALU_FLAGS_W-1:0] flags_in,
  input  logic [`ALU_DATA_W-1:0]  byp0,
  input  logic [`ALU_DATA_W-1:0]  byp1,
  output logic                    ret_valid,
  output logic                    ret_we,
  output logic [`ALU_DATA_W-1:0]  ret_data,
  output logic [`ALU_FLAGS_W-1:0] ret_flags
);

  exec_if    ex ();
  logic      add_done;
  unit_res_t add_res;
  logic      sh_done;
  unit_res_t sh_res;

  operand_bypass u_bypass (
    .clk      (clk),
    .rst_n    (rst_n),
    .issue_en (issue_en),
    .op       (op),
    .a_reg    (a_reg),
    .b_reg    (b_reg),
    .a_sel    (a_sel),
    .b_sel    (b_sel),
    .flags_in (flags_in),
    .byp0     (byp0),
    .byp1     (byp1),
    .ex       (ex.src)
  );

  // both units see every operation and claim their own opcodes
  add_unit u_add (
    .clk   (clk),
    .rst_n (rst_n),
    .ex    (ex.sink),
    .done  (add_done),
    .res   (add_res)
  );

  shift_unit u_shift (
    .clk   (clk),
    .rst_n (rst_n),
    .ex    (ex.sink),
    .done  (sh_done),
    .res   (sh_res)
  );

  result_merge u_merge (
    .clk       (clk),
    .rst_n     (rst_n),
    .add_done  (add_done),
    .add_res   (add_res),
    .sh_done   (sh_done),
    .sh_res    (sh_res),
    .ret_valid (ret_valid),
    .ret_we    (ret_we),
    .ret_data  (ret_data),
    .ret_flags (ret_flags)
  );

endmodule

`default_nettype wire

// File: alu_op_pkg.sv
`default_nettype none

`include "alu_cfg.svh"

package alu_op_pkg;

  typedef enum logic [7:0] {
    OP_ADD64 = 8'd1,
    OP_ADD32 = 8'd2,
    OP_SUB64 = 8'd3,
    OP_SUB32 = 8'd4,
    OP_CMP64 = 8'd5,
    OP_SHL64 = 8'd20,
    OP_SHR64 = 8'd21,
    OP_SAR64 = 8'd22,
    OP_SHL32 = 8'd23,
    OP_SHR32 = 8'd24,
    OP_SAR32 = 8'd25,
    OP_SBC64 = 8'd60,
    OP_ADC64 = 8'd61
  } op_code_e;

  typedef struct packed {
    logic [`ALU_OP_W-9:0] rsvd;
    op_code_e             code;
  } op_plain_t;

  // only meaningful for the add-with-carry class (codes 60 and 61)
  typedef struct packed {
    logic [`ALU_OP_W-11:0] rsvd;
    logic                  carry_fix;
    logic                  carry_from_flags;  // take carry-in from the incoming flags
    op_code_e              code;
  } op_carry_t;

  typedef union packed {
    op_plain_t plain;
    op_carry_t carry;
  } alu_op_u;

  typedef enum logic [2:0] {
    SRC_REG,
    SRC_BYP0,
    SRC_BYP1,
    SRC_BYP0_OLD,
    SRC_BYP1_OLD
  } src_sel_e;

endpackage

`default_nettype wire

// File: operand_bypass.sv
`default_nettype none

module operand_bypass
  import alu_op_pkg::*, alu_data_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     issue_en,
  input  alu_op_u  op,
  input  data_t    a_reg,
  input  data_t    b_reg,
  input  src_sel_e a_sel,
  input  src_sel_e b_sel,
  input  flags_t   flags_in,
  input  data_t    byp0,
  input  data_t    byp1,
  exec_if.src      ex
);

  logic     valid_q;
  alu_op_u  op_q;
  data_t    a_reg_q;
  data_t    b_reg_q;
  src_sel_e a_sel_q;
  src_sel_e b_sel_q;
  flags_t   flags_q;
  data_t    byp0_q;
  data_t    byp1_q;
  data_t    byp0_old;
  data_t    byp1_old;

  function automatic data_t pick(src_sel_e sel, data_t reg_val, data_t b0, data_t b1,
                                 data_t b0_old, data_t b1_old);
    data_t val;
    case (sel)
      SRC_BYP0:     val = b0;
      SRC_BYP1:     val = b1;
      SRC_BYP0_OLD: val = b0_old;
      SRC_BYP1_OLD: val = b1_old;
      default:      val = reg_val;
    endcase
    return val;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) valid_q <= 1'b0;
    else valid_q <= issue_en;
  end

  always_ff @(posedge clk) begin
    op_q     <= op;
    a_reg_q  <= a_reg;
    b_reg_q  <= b_reg;
    a_sel_q  <= a_sel;
    b_sel_q  <= b_sel;
    flags_q  <= flags_in;
    byp0_q   <= byp0;      // bus as it was at issue
    byp1_q   <= byp1;
    byp0_old <= byp0_q;    // one cycle before issue
    byp1_old <= byp1_q;
  end

  assign ex.valid    = valid_q;
  assign ex.op       = op_q;
  assign ex.flags_in = flags_q;
  assign ex.a = pick(a_sel_q, a_reg_q, byp0_q, byp1_q, byp0_old, byp1_old);
  assign ex.b = pick(b_sel_q, b_reg_q, byp0_q, byp1_q, byp0_old, byp1_old);

endmodule

`default_nettype wire

// File: result_merge.sv
`default_nettype none

module result_merge
  import alu_data_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      add_done,
  input  unit_res_t add_res,
  input  logic      sh_done,
  input  unit_res_t sh_res,
  output logic      ret_valid,
  output logic      ret_we,
  output data_t     ret_data,
  output flags_t    ret_flags
);

  unit_res_t pick;
  logic      any_done;

  // opcode sets of the two units never overlap, so at most one is done
  assign any_done = add_done || sh_done;
  assign pick     = add_done ? add_res : sh_res;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ret_valid <= 1'b0;
      ret_we    <= 1'b0;
    end else begin
      ret_valid <= any_done;
      ret_we    <= any_done && pick.we;
    end
  end

  always_ff @(posedge clk) begin
    if (any_done) begin
      ret_data  <= pick.result;  // held until the next result
      ret_flags <= pick.flags;
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# compiles the lane and its testbench with Verilator, then runs the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/100ps --top-module tb_alu_lane \
  -f all.f -o tb_alu_lane
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build returned status $status"
  exit $status
fi

./obj_dir/tb_alu_lane
status=$?
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit $status
fi

exit 0

// File: shift_unit.sv
`default_nettype none

`include "alu_cfg.svh"

module shift_unit
  import alu_op_pkg::*, alu_data_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  exec_if.sink      ex,
  output logic      done,
  output unit_res_t res
);

  op_code_e code;
  logic     is_mine;
  logic     is32;
  logic     arith;
  logic     dir_right;
  logic     fill;
  data_t    src;
  logic [5:0] amt;
  data_t    raw;
  data_t    shifted;
  flags_t   flags;

  assign code      = ex.op.plain.code;
  assign is_mine   = code inside {OP_SHL64, OP_SHR64, OP_SAR64, OP_SHL32, OP_SHR32, OP_SAR32};
  assign is32      = code inside {OP_SHL32, OP_SHR32, OP_SAR32};
  assign arith     = code inside {OP_SAR64, OP_SAR32};
  assign dir_right = !(code inside {OP_SHL64, OP_SHL32});

  // the 32-bit forms run on the full shifter with the upper half pre-filled
  assign fill = arith && ex.a[`ALU_HALF_W-1];
  assign src  = is32 ? {{(`ALU_DATA_W-`ALU_HALF_W){fill}}, ex.a[`ALU_HALF_W-1:0]} : ex.a;
  assign amt  = is32 ? {1'b0, ex.b[4:0]} : ex.b[5:0];

  always_comb begin
    if (!dir_right) raw = src << amt;
    else if (arith) raw = data_t'($signed(src) >>> amt);
    else raw = src >> amt;
  end

  assign shifted = is32 ? {{(`ALU_DATA_W-`ALU_HALF_W){1'b0}}, raw[`ALU_HALF_W-1:0]} : raw;

  always_comb begin
    flags.c = 1'b0;  // shifts leave carry and overflow clear
    flags.o = 1'b0;
    flags.z = shifted == '0;
    flags.s = is32 ? raw[`ALU_HALF_W-1] : raw[`ALU_DATA_W-1];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) done <= 1'b0;
    else done <= ex.valid && is_mine;
  end

  always_ff @(posedge clk) begin
    if (ex.valid && is_mine) begin
      res.result <= shifted;
      res.flags  <= flags;
      res.we     <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: tb_alu_lane.sv
`default_nettype none

`include "alu_cfg.svh"

module tb_alu_lane
  import alu_op_pkg::*, alu_data_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    data_t  data;
    flags_t flags;
    logic   we;
    logic   valid;  // low for codes that no unit claims
  } exp_t;

  typedef struct {
    logic [`ALU_OP_W-1:0] op;
    data_t                a_reg;
    data_t                b_reg;
    src_sel_e             a_sel;
    src_sel_e             b_sel;
    data_t                byp0;
    data_t                byp1;
    flags_t               fin;
    exp_t                 exp;
  } row_t;

  typedef struct {
    int idx;
    int issue_cyc;
  } pend_t;

  logic                 clk;
  logic                 rst_n;
  logic                 issue_en;
  logic [`ALU_OP_W-1:0] op;
  data_t                a_reg;
  data_t                b_reg;
  src_sel_e             a_sel;
  src_sel_e             b_sel;
  flags_t               flags_in;
  data_t                byp0;
  data_t                byp1;
  logic                 ret_valid;
  logic                 ret_we;
  data_t                ret_data;
  logic [3:0]           ret_flags;

  integer seed = 72767;
  int     cyc = 0;  // rising edges seen so far
  row_t   rows[64];
  int     n_rows = 0;
  int     n_valid = 0;
  data_t  byp_init0;
  data_t  byp_init1;
  pend_t  pend[$];

  alu_lane u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .issue_en  (issue_en),
    .op        (op),
    .a_reg     (a_reg),
    .b_reg     (b_reg),
    .a_sel     (a_sel),
    .b_sel     (b_sel),
    .flags_in  (flags_in),
    .byp0      (byp0),
    .byp1      (byp1),
    .ret_valid (ret_valid),
    .ret_we    (ret_we),
    .ret_data  (ret_data),
    .ret_flags (ret_flags)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  function automatic data_t rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic flags_t rand_flags();
    data_t r;
    r = rand64();
    return r[3:0];
  endfunction

  function automatic data_t select_operand(src_sel_e sel, data_t reg_val, data_t bus0,
                                           data_t bus1, data_t bus0_prev, data_t bus1_prev);
    case (sel)
      SRC_BYP0:     return bus0;
      SRC_BYP1:     return bus1;
      SRC_BYP0_OLD: return bus0_prev;  // bus as it was one edge before issue
      SRC_BYP1_OLD: return bus1_prev;
      default:      return reg_val;
    endcase
  endfunction

  // overflow comes out as carry into the top bit xor carry out of it
  function automatic exp_t model_add(logic [7:0] code, logic cff, logic cfix, logic fin_c,
                                     data_t a, data_t b);
    exp_t        e;
    logic        invert;
    logic        cin;
    logic        c_top;
    data_t       bx;
    logic [64:0] w;
    logic [32:0] h;
    invert = code inside {OP_SUB64, OP_SUB32, OP_CMP64, OP_SBC64};
    if (code inside {OP_ADC64, OP_SBC64}) cin = cff ? fin_c : cfix;
    else cin = invert;
    bx = invert ? ~b : b;
    e = '0;
    if (code inside {OP_ADD32, OP_SUB32}) begin
      h = {1'b0, a[31:0]} + {1'b0, bx[31:0]} + {32'd0, cin};
      e.data    = {32'd0, h[31:0]};
      e.flags.c = h[32];
      e.flags.s = h[31];
      c_top     = h[31] ^ a[31] ^ bx[31];
    end else begin
      w = {1'b0, a} + {1'b0, bx} + {64'd0, cin};
      e.data    = w[63:0];
      e.flags.c = w[64];
      e.flags.s = w[63];
      c_top     = w[63] ^ a[63] ^ bx[63];
    end
    e.flags.z = e.data == '0;
    e.flags.o = c_top ^ e.flags.c;
    e.we      = code != OP_CMP64;
    e.valid   = 1'b1;
    return e;
  endfunction

  // shifts one bit at a time and lets the sign bit refill itself for sar
  function automatic exp_t model_shift(logic [7:0] code, data_t a, data_t b);
    exp_t        e;
    logic        left;
    logic        arith;
    logic [31:0] h;
    data_t       w;
    int          amt;
    int          k;
    left  = code inside {OP_SHL64, OP_SHL32};
    arith = code inside {OP_SAR64, OP_SAR32};
    e = '0;
    if (code inside {OP_SHL32, OP_SHR32, OP_SAR32}) begin
      h   = a[31:0];
      amt = int'(b[4:0]);
      for (k = 0; k < amt; k++)
        h = left ? {h[30:0], 1'b0} : {arith & h[31], h[31:1]};
      e.data    = {32'd0, h};
      e.flags.s = h[31];
    end else begin
      w   = a;
      amt = int'(b[5:0]);
      for (k = 0; k < amt; k++)
        w = left ? {w[62:0], 1'b0} : {arith & w[63], w[63:1]};
      e.data    = w;
      e.flags.s = w[63];
    end
    e.flags.z = e.data == '0;
    e.we      = 1'b1;
    e.valid   = 1'b1;
    return e;
  endfunction

  function automatic exp_t model_op(logic [`ALU_OP_W-1:0] word, flags_t fin, data_t a,
                                    data_t b);
    alu_op_u u;
    u = word;
    case (u.plain.code)
      OP_ADD64, OP_ADD32, OP_SUB64, OP_SUB32, OP_CMP64:
        return model_add(u.plain.code, 1'b0, 1'b0, fin.c, a, b);
      OP_ADC64, OP_SBC64:
        return model_add(u.carry.code, u.carry.carry_from_flags, u.carry.carry_fix, fin.c,
                         a, b);
      OP_SHL64, OP_SHR64, OP_SAR64, OP_SHL32, OP_SHR32, OP_SAR32:
        return model_shift(u.plain.code, a, b);
      default: return '0;
    endcase
  endfunction

  task automatic add_row(input logic [7:0] code, input logic cff, input logic cfix,
                         input data_t a, input data_t b, input src_sel_e as,
                         input src_sel_e bs, input flags_t fin);
    rows[n_rows].op    = {{(`ALU_OP_W-10){1'b0}}, cfix, cff, code};
    rows[n_rows].a_reg = a;
    rows[n_rows].b_reg = b;
    rows[n_rows].a_sel = as;
    rows[n_rows].b_sel = bs;
    rows[n_rows].fin   = fin;
    rows[n_rows].byp0  = rand64();  // buses move every cycle
    rows[n_rows].byp1  = rand64();
    n_rows++;
  endtask

  task automatic build_table();
    data_t  a;
    data_t  b;
    data_t  opa;
    data_t  opb;
    flags_t fin;
    int     i;
    int     k;
    byp_init0 = rand64();
    byp_init1 = rand64();
    for (i = 0; i < 8; i++)
      add_row(8'(1 + i % 4), 1'b0, 1'b0, rand64(), rand64(), SRC_REG, SRC_REG, rand_flags());
    a = rand64();
    add_row(OP_SUB64, 1'b0, 1'b0, a, a, SRC_REG, SRC_REG, rand_flags());
    add_row(OP_ADD64, 1'b0, 1'b0, 64'h7fff_ffff_ffff_ffff, 64'd1, SRC_REG, SRC_REG, '0);
    add_row(8'd99, 1'b0, 1'b0, rand64(), rand64(), SRC_REG, SRC_REG, rand_flags());
    add_row(OP_CMP64, 1'b0, 1'b0, rand64(), rand64(), SRC_REG, SRC_REG, rand_flags());
    add_row(OP_CMP64, 1'b0, 1'b0, a, a, SRC_REG, SRC_REG, rand_flags());
    // opposite values on the unused carry source show which one was taken
    for (i = 0; i < 8; i++) begin
      fin = rand_flags();
      if (i[1]) begin
        fin.c = i[0];
        add_row(i[2] ? OP_SBC64 : OP_ADC64, 1'b1, !i[0], rand64(), rand64(), SRC_REG,
                SRC_REG, fin);
      end else begin
        fin.c = !i[0];
        add_row(i[2] ? OP_SBC64 : OP_ADC64, 1'b0, i[0], rand64(), rand64(), SRC_REG,
                SRC_REG, fin);
      end
    end
    for (i = 0; i < 6; i++) begin
      for (k = 0; k < 3; k++) begin
        a = rand64();
        b = rand64();
        if (k == 0) b[5:0] = 6'd0;
        else if (k == 1) begin
          b[4:0] = 5'd31;
          if (i < 3) b[5] = 1'b1;  // 63 for the 64-bit forms
          a[63] = 1'b1;
          a[31] = 1'b1;
        end
        add_row(8'(20 + i), 1'b0, 1'b0, a, b, SRC_REG, SRC_REG, rand_flags());
      end
    end
    for (i = 0; i < 5; i++)
      add_row(OP_ADD64, 1'b0, 1'b0, rand64(), rand64(), src_sel_e'(i), src_sel_e'(4 - i),
              rand_flags());
    add_row(OP_SUB64, 1'b0, 1'b0, rand64(), rand64(), SRC_BYP1_OLD, SRC_BYP0_OLD, '0);
    add_row(8'd0, 1'b0, 1'b0, rand64(), rand64(), SRC_REG, SRC_REG, rand_flags());
    for (i = 0; i < n_rows; i++) begin
      opa = select_operand(rows[i].a_sel, rows[i].a_reg, rows[i].byp0, rows[i].byp1,
                           i == 0 ? byp_init0 : rows[i-1].byp0,
                           i == 0 ? byp_init1 : rows[i-1].byp1);
      opb = select_operand(rows[i].b_sel, rows[i].b_reg, rows[i].byp0, rows[i].byp1,
                           i == 0 ? byp_init0 : rows[i-1].byp0,
                           i == 0 ? byp_init1 : rows[i-1].byp1);
      rows[i].exp = model_op(rows[i].op, rows[i].fin, opa, opb);
      if (rows[i].exp.valid) n_valid++;
    end
  endtask

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s got %h exp %h", name, got, exp);
      $display("sim failed");
      $fatal(1, "wrong value on %s", name);
    end
  endtask

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "run stopped");
  endtask

  task automatic wait_ret();
    int n;
    n = 0;
    @(negedge clk);
    while (!ret_valid) begin
      n++;
      if (n >= 20) stop_run("timeout, ret_valid did not rise within 20 cycles");
      @(negedge clk);
    end
  endtask

  task automatic drive_rows();
    pend_t p;
    int    i;
    for (i = 0; i < n_rows; i++) begin
      @(negedge clk);
      issue_en = 1'b1;
      op       = rows[i].op;
      a_reg    = rows[i].a_reg;
      b_reg    = rows[i].b_reg;
      a_sel    = rows[i].a_sel;
      b_sel    = rows[i].b_sel;
      flags_in = rows[i].fin;
      byp0     = rows[i].byp0;
      byp1     = rows[i].byp1;
      if (rows[i].exp.valid) begin
        p.idx       = i;
        p.issue_cyc = cyc + 1;  // the next rising edge takes it
        pend.push_back(p);
      end
    end
    @(negedge clk);
    issue_en = 1'b0;
  endtask

  task automatic check_results();
    pend_t p;
    row_t  r;
    int    i;
    for (i = 0; i < n_valid; i++) begin
      wait_ret();
      if (pend.size() == 0) stop_run("ret_valid rose with no operation in flight");
      p = pend.pop_front();
      r = rows[p.idx];
      compare("ret_cycle", 64'(cyc), 64'(p.issue_cyc + 2));  // issue edge is the first of three
      compare("ret_we", {63'd0, ret_we}, {63'd0, r.exp.we});
      if (r.exp.we) compare("ret_data", ret_data, r.exp.data);
      compare("ret_flags", {60'd0, ret_flags}, {60'd0, r.exp.flags});
    end
    // the trailing unknown opcode must stay silent
    repeat (8) begin
      @(negedge clk);
      compare("ret_valid", {63'd0, ret_valid}, 64'd0);
    end
  endtask

  initial begin
    build_table();
    rst_n    = 1'b0;
    issue_en = 1'b0;
    op       = '0;
    a_reg    = '0;
    b_reg    = '0;
    a_sel    = SRC_REG;
    b_sel    = SRC_REG;
    flags_in = '0;
    byp0     = byp_init0;
    byp1     = byp_init1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    fork
      drive_rows();
      check_results();
    join
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire
